//--- source/rf_pkg.sv
package rf_pkg;

    // Byte path
    localparam int data_width = 8;

    // Buffer geometry, scaled down for simulation
    localparam int fifo_depth = 64;
    localparam int count_width = 7;

    // Uplink burst starts at this occupancy
    localparam int burst_threshold = 8;

    // Cycles of MCU silence before a partial burst is released
    localparam int uplink_quiet_limit = 40;

    // Settling time before received node bytes go to the MCU
    localparam int downlink_wait_limit = 20;

    // {m1, m0} code of the transparent mode
    localparam logic [1:0] mode_normal = 2'd0;

    // Controller state codes, shared by both paths
    localparam int state_width = 2;
    localparam logic [state_width-1:0] ctrl_idle = 2'd0;
    localparam logic [state_width-1:0] ctrl_waiting = 2'd1;
    localparam logic [state_width-1:0] ctrl_sending = 2'd2;

endpackage

//--- source/byte_fifo.sv
`timescale 1ns/1ps

module byte_fifo #(
    parameter int depth = rf_pkg::fifo_depth
) (
    input  logic                             mode0_clk,
    input  logic                             rst_n,
    input  logic                             push,
    input  logic [rf_pkg::data_width-1:0]    push_data,
    input  logic                             pop,
    output logic [rf_pkg::data_width-1:0]    pop_data,
    output logic                             empty,
    output logic                             full,
    output logic [rf_pkg::count_width-1:0]   count
);

    import rf_pkg::*;

    localparam int ptr_width = $clog2(depth);

    logic [data_width-1:0] mem [depth];
    logic [ptr_width-1:0]  wr_ptr;
    logic [ptr_width-1:0]  rd_ptr;
    logic                  do_push;
    logic                  do_pop;

    // Requests against a full or empty buffer are dropped here
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign empty = (count == '0);
    assign full  = (count == count_width'(depth));

    // First word fall through
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge mode0_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge mode0_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ptr_width'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_width'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Push and pop together leave the occupancy alone
            case ({do_push, do_pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- source/idle_timer.sv
`timescale 1ns/1ps

module idle_timer #(
    parameter int limit = 16
) (
    input  logic mode0_clk,
    input  logic rst_n,
    input  logic restart,
    input  logic run,
    output logic expired
);

    localparam int cnt_width = $clog2(limit + 1);

    logic [cnt_width-1:0] cnt;

    // Saturates at the limit, so expired holds until the next restart
    assign expired = (cnt == cnt_width'(limit));

    always_ff @(posedge mode0_clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (restart) begin
            cnt <= '0;
        end else if (run && !expired) begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

//--- source/uplink_ctrl.sv
`timescale 1ns/1ps

module uplink_ctrl (
    input  logic                             mode0_clk,
    input  logic                             rst_n,
    input  logic                             mode_en,
    input  logic                             mcu_rx_valid,
    input  logic                             fifo_empty,
    input  logic                             fifo_full,
    input  logic [rf_pkg::count_width-1:0]   fifo_count,
    input  logic                             node_tx_ready,
    output logic                             mcu_rx_ready,
    output logic                             fifo_push,
    output logic                             fifo_pop,
    output logic                             node_tx_valid,
    output logic                             idle
);

    import rf_pkg::*;

    logic [state_width-1:0] state;
    logic                   quiet_expired;
    logic                   burst_start;

    // MCU side accepts while there is room
    assign mcu_rx_ready = mode_en && !fifo_full;
    assign fifo_push    = mcu_rx_valid && mcu_rx_ready;

    // Node side drains only during a burst
    assign node_tx_valid = mode_en && (state == ctrl_sending) && !fifo_empty;
    assign fifo_pop      = node_tx_valid && node_tx_ready;

    assign idle = (state == ctrl_idle);

    // Every accepted byte restarts the quiet window
    idle_timer #(
        .limit(uplink_quiet_limit)
    ) quiet_timer (
        .mode0_clk(mode0_clk),
        .rst_n(rst_n),
        .restart(fifo_push),
        .run(mode_en),
        .expired(quiet_expired)
    );

    assign burst_start = (fifo_count >= count_width'(burst_threshold)) || quiet_expired;

    always_ff @(posedge mode0_clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ctrl_idle;
        end else if (mode_en) begin
            case (state)
                ctrl_idle: begin
                    if (!fifo_empty) begin
                        state <= ctrl_waiting;
                    end
                end
                ctrl_waiting: begin
                    if (burst_start) begin
                        state <= ctrl_sending;
                    end
                end
                ctrl_sending: begin
                    if (fifo_empty) begin
                        state <= ctrl_idle;
                    end
                end
                default: state <= ctrl_idle;
            endcase
        end
    end

endmodule

//--- source/downlink_ctrl.sv
`timescale 1ns/1ps

module downlink_ctrl (
    input  logic mode0_clk,
    input  logic rst_n,
    input  logic mode_en,
    input  logic node_rx_valid,
    input  logic fifo_empty,
    input  logic fifo_full,
    input  logic mcu_tx_ready,
    output logic node_rx_ready,
    output logic fifo_push,
    output logic fifo_pop,
    output logic mcu_tx_valid,
    output logic idle
);

    import rf_pkg::*;

    logic [state_width-1:0] state;
    logic                   settle_restart;
    logic                   settle_done;

    assign node_rx_ready = mode_en && !fifo_full;
    assign fifo_push     = node_rx_valid && node_rx_ready;

    assign mcu_tx_valid = mode_en && (state == ctrl_sending) && !fifo_empty;
    assign fifo_pop     = mcu_tx_valid && mcu_tx_ready;

    assign idle = (state == ctrl_idle);

    // Timer is held clear until idle sees data.
    // It already counts in the cycle that leaves idle, so the waiting
    // state lasts exactly downlink_wait_limit cycles.
    assign settle_restart = (state == ctrl_sending) || ((state == ctrl_idle) && fifo_empty);

    idle_timer #(
        .limit(downlink_wait_limit)
    ) settle_timer (
        .mode0_clk(mode0_clk),
        .rst_n(rst_n),
        .restart(settle_restart),
        .run(mode_en),
        .expired(settle_done)
    );

    always_ff @(posedge mode0_clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ctrl_idle;
        end else if (mode_en) begin
            case (state)
                ctrl_idle: begin
                    if (!fifo_empty) begin
                        state <= ctrl_waiting;
                    end
                end
                ctrl_waiting: begin
                    if (settle_done) begin
                        state <= ctrl_sending;
                    end
                end
                // Late node bytes are drained in the same pass
                ctrl_sending: begin
                    if (fifo_empty) begin
                        state <= ctrl_idle;
                    end
                end
                default: state <= ctrl_idle;
            endcase
        end
    end

endmodule

//--- source/rf_transceiver_top.sv
`timescale 1ns/1ps

module rf_transceiver_top (
    input  logic                            mode0_clk,
    input  logic                            rst_n,
    input  logic                            m0,
    input  logic                            m1,
    // MCU receive port
    input  logic [rf_pkg::data_width-1:0]   mcu_rx_data,
    input  logic                            mcu_rx_valid,
    output logic                            mcu_rx_ready,
    // Node transmit port
    output logic [rf_pkg::data_width-1:0]   node_tx_data,
    output logic                            node_tx_valid,
    input  logic                            node_tx_ready,
    // Node receive port
    input  logic [rf_pkg::data_width-1:0]   node_rx_data,
    input  logic                            node_rx_valid,
    output logic                            node_rx_ready,
    // MCU transmit port
    output logic [rf_pkg::data_width-1:0]   mcu_tx_data,
    output logic                            mcu_tx_valid,
    input  logic                            mcu_tx_ready,
    output logic                            aux
);

    import rf_pkg::*;

    logic                   mode_en;
    logic                   up_push;
    logic                   up_pop;
    logic                   up_empty;
    logic                   up_full;
    logic [count_width-1:0] up_count;
    logic                   up_idle;
    logic                   down_push;
    logic                   down_pop;
    logic                   down_empty;
    logic                   down_full;
    logic                   down_idle;

    assign mode_en = ({m1, m0} == mode_normal);

    // Device is free only when neither path holds data
    assign aux = up_idle && down_idle;

    // MCU to node
    byte_fifo #(
        .depth(fifo_depth)
    ) up_fifo (
        .mode0_clk(mode0_clk),
        .rst_n(rst_n),
        .push(up_push),
        .push_data(mcu_rx_data),
        .pop(up_pop),
        .pop_data(node_tx_data),
        .empty(up_empty),
        .full(up_full),
        .count(up_count)
    );

    uplink_ctrl i_uplink_ctrl (
        .mode0_clk(mode0_clk),
        .rst_n(rst_n),
        .mode_en(mode_en),
        .mcu_rx_valid(mcu_rx_valid),
        .fifo_empty(up_empty),
        .fifo_full(up_full),
        .fifo_count(up_count),
        .node_tx_ready(node_tx_ready),
        .mcu_rx_ready(mcu_rx_ready),
        .fifo_push(up_push),
        .fifo_pop(up_pop),
        .node_tx_valid(node_tx_valid),
        .idle(up_idle)
    );

    // Node to MCU, occupancy not needed on this side
    byte_fifo #(
        .depth(fifo_depth)
    ) down_fifo (
        .mode0_clk(mode0_clk),
        .rst_n(rst_n),
        .push(down_push),
        .push_data(node_rx_data),
        .pop(down_pop),
        .pop_data(mcu_tx_data),
        .empty(down_empty),
        .full(down_full),
        .count()
    );

    downlink_ctrl i_downlink_ctrl (
        .mode0_clk(mode0_clk),
        .rst_n(rst_n),
        .mode_en(mode_en),
        .node_rx_valid(node_rx_valid),
        .fifo_empty(down_empty),
        .fifo_full(down_full),
        .mcu_tx_ready(mcu_tx_ready),
        .node_rx_ready(node_rx_ready),
        .fifo_push(down_push),
        .fifo_pop(down_pop),
        .mcu_tx_valid(mcu_tx_valid),
        .idle(down_idle)
    );

endmodule

//--- sim/rf_transceiver_asserts.sv
`timescale 1ns/1ps

module rf_transceiver_asserts (
    input logic                          mode0_clk,
    input logic                          rst_n,
    input logic                          m0,
    input logic                          m1,
    input logic                          mcu_rx_ready,
    input logic                          node_rx_ready,
    input logic [rf_pkg::data_width-1:0] node_tx_data,
    input logic                          node_tx_valid,
    input logic                          node_tx_ready,
    input logic [rf_pkg::data_width-1:0] mcu_tx_data,
    input logic                          mcu_tx_valid,
    input logic                          mcu_tx_ready,
    input logic                          aux
);

    // A stalled byte stays put unless the mode pulls the valid away
    node_tx_hold: assert property (@(posedge mode0_clk) disable iff (!rst_n)
        node_tx_valid && !node_tx_ready |=> (node_tx_valid && $stable(node_tx_data)) || m0 || m1)
        else $error("node_tx_valid dropped or node_tx_data changed while stalled");

    mcu_tx_hold: assert property (@(posedge mode0_clk) disable iff (!rst_n)
        mcu_tx_valid && !mcu_tx_ready |=> (mcu_tx_valid && $stable(mcu_tx_data)) || m0 || m1)
        else $error("mcu_tx_valid dropped or mcu_tx_data changed while stalled");

    aux_busy: assert property (@(posedge mode0_clk) disable iff (!rst_n)
        node_tx_valid || mcu_tx_valid |-> !aux)
        else $error("aux high while an output byte is offered");

    ready_mode: assert property (@(posedge mode0_clk) disable iff (!rst_n)
        m0 || m1 |-> !mcu_rx_ready && !node_rx_ready)
        else $error("input ready high outside mode 0");

endmodule

bind rf_transceiver_top rf_transceiver_asserts i_asserts (.*);

//--- sim/tb_rf_transceiver.sv
`timescale 1ns/1ps

module tb_rf_transceiver;

    import rf_pkg::*;

    localparam int reset_cycles = 16;
    localparam int n_entries = 5;

    // Columns: direction (1 = downlink), byte count, {m1, m0}, back-pressure
    localparam bit         tbl_dir [n_entries]   = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
    localparam int         tbl_count [n_entries] = '{8, 3, 6, 4, 10};
    localparam logic [1:0] tbl_mode [n_entries]  = '{2'd0, 2'd0, 2'd0, 2'd2, 2'd0};
    localparam bit         tbl_bp [n_entries]    = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b1};

    logic                  mode0_clk;
    logic                  rst_n;
    logic                  m0;
    logic                  m1;
    logic [data_width-1:0] mcu_rx_data;
    logic                  mcu_rx_valid;
    logic                  mcu_rx_ready;
    logic [data_width-1:0] node_tx_data;
    logic                  node_tx_valid;
    logic                  node_tx_ready;
    logic [data_width-1:0] node_rx_data;
    logic                  node_rx_valid;
    logic                  node_rx_ready;
    logic [data_width-1:0] mcu_tx_data;
    logic                  mcu_tx_valid;
    logic                  mcu_tx_ready;
    logic                  aux;

    integer                seed;
    int                    cyc;
    int                    last_up_cyc;
    int                    first_down_cyc;
    bit                    bp_active;
    bit                    check_quiet;
    int                    data_errors;
    int                    signal_errors;
    int                    timing_errors;
    logic [data_width-1:0] up_expect [$];
    logic [data_width-1:0] down_expect [$];

    rf_transceiver_top i_rf_transceiver_top (.*);

    initial begin
        mode0_clk = 1'b0;
        forever #5 mode0_clk = ~mode0_clk;
    end

    function automatic int timeout_cycles();
        int total;
        total = uplink_quiet_limit + downlink_wait_limit + 50;
        for (int e = 0; e < n_entries; e++) begin
            total += 4 * tbl_count[e];
        end
        return total;
    endfunction

    task automatic expect_bit(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("[ERROR] %0t: %s got %b, expected %b", $time, name, got, want);
            signal_errors++;
        end
    endtask

    task automatic compare_byte(input bit down, input logic [data_width-1:0] got);
        logic [data_width-1:0] want;
        string                 name;
        name = down ? "mcu_tx_data" : "node_tx_data";
        if ((down && down_expect.size() == 0) || (!down && up_expect.size() == 0)) begin
            $display("%0t: %s carried a byte that was never sent", $time, name);
            data_errors++;
        end else begin
            if (down) begin
                want = down_expect.pop_front();
            end else begin
                want = up_expect.pop_front();
            end
            if (got !== want) begin
                $display("[ERROR] %0t: %s got %h, expected %h", $time, name, got, want);
                data_errors++;
            end
        end
    endtask

    // Holds valid and data until the DUT takes the byte
    task automatic send_byte(input bit down, input logic [data_width-1:0] value);
        bit taken;
        taken = 1'b0;
        @(negedge mode0_clk);
        if (down) begin
            node_rx_data  = value;
            node_rx_valid = 1'b1;
        end else begin
            mcu_rx_data  = value;
            mcu_rx_valid = 1'b1;
        end
        while (!taken) begin
            @(posedge mode0_clk);
            taken = down ? node_rx_ready : mcu_rx_ready;
        end
        if (down) begin
            down_expect.push_back(value);
            if (first_down_cyc < 0) begin
                first_down_cyc = cyc;
            end
        end else begin
            up_expect.push_back(value);
            last_up_cyc = cyc;
        end
    endtask

    task automatic wait_drained();
        while (up_expect.size() != 0 || down_expect.size() != 0 || node_tx_valid ||
               mcu_tx_valid) begin
            @(negedge mode0_clk);
        end
        // Controllers fall back to idle one cycle after the buffer empties
        repeat (2) @(negedge mode0_clk);
        expect_bit("aux", aux, 1'b1);
    endtask

    task automatic run_entry(input int e);
        int  n;
        bit  down;
        n = tbl_count[e];
        down = tbl_dir[e];
        first_down_cyc = -1;
        bp_active = tbl_bp[e];
        check_quiet = !down && (n < burst_threshold);
        for (int i = 0; i < n; i++) begin
            send_byte(down, data_width'($random(seed)));
        end
        @(negedge mode0_clk);
        mcu_rx_valid  = 1'b0;
        node_rx_valid = 1'b0;
        expect_bit("aux", aux, 1'b0);
        if (tbl_mode[e] != mode_normal) begin
            // Leave mode 0 while the burst is on offer
            while (!node_tx_valid && !mcu_tx_valid) begin
                @(negedge mode0_clk);
            end
            {m1, m0} = tbl_mode[e];
            // Offer bytes on both inputs, none may be taken
            mcu_rx_valid  = 1'b1;
            node_rx_valid = 1'b1;
            repeat (n) begin
                @(posedge mode0_clk);
                expect_bit("mcu_rx_ready", mcu_rx_ready, 1'b0);
                expect_bit("node_rx_ready", node_rx_ready, 1'b0);
            end
            @(negedge mode0_clk);
            mcu_rx_valid  = 1'b0;
            node_rx_valid = 1'b0;
            {m1, m0} = mode_normal;
        end
        wait_drained();
        bp_active = 1'b0;
        check_quiet = 1'b0;
    endtask

    // Output back-pressure
    always @(negedge mode0_clk) begin
        node_tx_ready = bp_active ? ($random(seed) % 4 != 0) : 1'b1;
        mcu_tx_ready  = bp_active ? ($random(seed) % 4 != 0) : 1'b1;
    end

    always @(negedge mode0_clk) begin
        if (rst_n) begin
            cyc <= cyc + 1;
        end
        if (cyc >= timeout_cycles()) begin
            $display("Timeout: bytes still pending after %0d cycles", cyc);
            $display("TEST FAILED");
            $finish;
        end
    end

    always @(posedge mode0_clk) begin
        if (rst_n) begin
            if (node_tx_valid && node_tx_ready) begin
                compare_byte(1'b0, node_tx_data);
            end
            if (mcu_tx_valid && mcu_tx_ready) begin
                compare_byte(1'b1, mcu_tx_data);
            end
            if (check_quiet && node_tx_valid && (cyc - last_up_cyc < uplink_quiet_limit)) begin
                $display("%0t: uplink burst began before the MCU quiet time ran out", $time);
                timing_errors++;
            end
            if (mcu_tx_valid && first_down_cyc >= 0 &&
                (cyc - first_down_cyc < downlink_wait_limit)) begin
                $display("%0t: downlink drain began before the settling wait ended", $time);
                timing_errors++;
            end
            if ((m0 || m1) && (node_tx_valid || mcu_tx_valid)) begin
                $display("%0t: an output byte was offered outside mode 0", $time);
                timing_errors++;
            end
        end
    end

    initial begin
        seed = 32'h1c8b;
        cyc = 0;
        last_up_cyc = 0;
        first_down_cyc = -1;
        bp_active = 1'b0;
        check_quiet = 1'b0;
        data_errors = 0;
        signal_errors = 0;
        timing_errors = 0;
        rst_n = 1'b0;
        {m1, m0} = mode_normal;
        mcu_rx_data = '0;
        mcu_rx_valid = 1'b0;
        node_rx_data = '0;
        node_rx_valid = 1'b0;
        node_tx_ready = 1'b1;
        mcu_tx_ready = 1'b1;
        repeat (reset_cycles) begin
            @(negedge mode0_clk);
            expect_bit("aux", aux, 1'b1);
            expect_bit("node_tx_valid", node_tx_valid, 1'b0);
            expect_bit("mcu_tx_valid", mcu_tx_valid, 1'b0);
        end
        rst_n = 1'b1;
        @(negedge mode0_clk);
        expect_bit("aux", aux, 1'b1);
        expect_bit("node_tx_valid", node_tx_valid, 1'b0);
        expect_bit("mcu_tx_valid", mcu_tx_valid, 1'b0);
        for (int e = 0; e < n_entries; e++) begin
            run_entry(e);
        end
        $display("Errors: data %0d, signal %0d, timing %0d",
                 data_errors, signal_errors, timing_errors);
        if (data_errors + signal_errors + timing_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- files.f
source/rf_pkg.sv
source/byte_fifo.sv
source/idle_timer.sv
source/uplink_ctrl.sv
source/downlink_ctrl.sv
source/rf_transceiver_top.sv
sim/rf_transceiver_asserts.sv
sim/tb_rf_transceiver.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_rf_transceiver
FILELIST  = files.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TEST PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
